// File: compile.f
+incdir+hw
hw/clint_msg_pkg.sv
hw/clint_map_pkg.sv
hw/clint_cmd_if.sv
hw/clint_cmd_buffer.sv
hw/clint_timer.sv
hw/clint_regs.sv
hw/clint_top.sv
test/clint_assert.sv
test/clint_tb.sv

// File: hw/clint_cmd_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module clint_cmd_buffer (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  logic                     cmd_v_i,
  output logic                     cmd_ready_o,
  input  clint_msg_pkg::clint_cmd_s cmd_i,

  clint_cmd_if.buf_mp              cmd_o
);
  import clint_msg_pkg::*;
  import clint_map_pkg::*;

  clint_buf_state_e state_r;
  clint_cmd_s       cmd_r;
  logic             accept;

  assign cmd_ready_o = (state_r == e_buf_empty);
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_buf_empty;
    end else begin
      case (state_r)
        e_buf_empty: begin
          if (cmd_v_i) begin
            state_r <= e_buf_full;
          end
        end
        e_buf_full: begin
          if (cmd_o.yumi) begin // entry consumed downstream
            state_r <= e_buf_empty;
          end
        end
        default: state_r <= e_buf_empty;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_r <= cmd_i;
    end
  end

  assign cmd_o.v   = (state_r == e_buf_full);
  assign cmd_o.cmd = cmd_r;

endmodule

`default_nettype wire

// File: hw/clint_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

interface clint_cmd_if;
  import clint_msg_pkg::*;

  logic       v; // buffer holds an entry
  clint_cmd_s cmd;
  logic       yumi; // only while v, pops the entry

  modport buf_mp (
    output v,
    output cmd,
    input  yumi
  );

  modport regs_mp (
    input  v,
    input  cmd,
    output yumi
  );

endinterface

interface clint_timer_if;

  logic                     mtime_set; // load mtime_wdata this cycle
  logic [`CLINT_DATA_W-1:0] mtime_wdata;
  logic [`CLINT_DATA_W-1:0] mtimecmp;
  logic [`CLINT_DATA_W-1:0] mtime;

  modport regs_mp (
    output mtime_set,
    output mtime_wdata,
    output mtimecmp,
    input  mtime
  );

  modport timer_mp (
    input  mtime_set,
    input  mtime_wdata,
    input  mtimecmp,
    output mtime
  );

endinterface

`default_nettype wire

// File: hw/clint_consts.svh
`ifndef CLINT_CONSTS_SVH
`define CLINT_CONSTS_SVH

// widths of the command and response fields
`define CLINT_DATA_W 64
`define CLINT_ADDR_W 16
`define CLINT_TAG_W 8 // opaque requester tag, echoed back

// register offsets inside the slice
`define CLINT_MSIP_OFS 16'h0000
`define CLINT_MTIMECMP_OFS 16'h4000
`define CLINT_MEIP_OFS 16'h8000
`define CLINT_MTIME_OFS 16'hBFF8

// mtime advances once every this many clocks
`define CLINT_TICK_DIV 8

`endif

// File: hw/clint_map_pkg.sv
`default_nettype none

package clint_map_pkg;

  // decoded target of the buffered command
  typedef enum logic [2:0] {
    e_reg_msip     = 3'd0,
    e_reg_mtimecmp = 3'd1,
    e_reg_meip     = 3'd2,
    e_reg_mtime    = 3'd3,
    e_reg_none     = 3'd4 // unmapped offset
  } clint_reg_e;

  typedef enum logic {
    e_buf_empty = 1'b0,
    e_buf_full  = 1'b1
  } clint_buf_state_e;

endpackage

`default_nettype wire

// File: hw/clint_msg_pkg.sv
`default_nettype none

`include "clint_consts.svh"

package clint_msg_pkg;

  typedef enum logic [1:0] {
    e_op_rd    = 2'b00,
    e_op_wr    = 2'b01,
    e_op_uc_rd = 2'b10, // uncached read
    e_op_uc_wr = 2'b11
  } clint_op_e;

  typedef struct packed {
    clint_op_e                opcode;
    logic [`CLINT_ADDR_W-1:0] addr;
    logic [`CLINT_TAG_W-1:0]  tag;
    logic [`CLINT_DATA_W-1:0] data;
  } clint_cmd_s;

  // opcode, addr and tag come back from the command
  typedef struct packed {
    clint_op_e                opcode;
    logic [`CLINT_ADDR_W-1:0] addr;
    logic [`CLINT_TAG_W-1:0]  tag;
    logic [`CLINT_DATA_W-1:0] data; // read value, zero for writes
  } clint_resp_s;

endpackage

`default_nettype wire

// File: hw/clint_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_regs (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  clint_cmd_if.regs_mp               cmd,
  clint_timer_if.regs_mp             tmr,

  input  logic                       resp_yumi_i,
  output clint_msg_pkg::clint_resp_s resp_o,

  output logic                       software_irq_o,
  output logic                       external_irq_o
);
  import clint_msg_pkg::*;
  import clint_map_pkg::*;

  clint_reg_e               reg_sel;
  logic                     wr_not_rd;
  logic                     retire;
  logic                     wr_commit;
  logic                     msip_r;
  logic                     meip_r;
  logic [`CLINT_DATA_W-1:0] mtimecmp_r;
  logic [`CLINT_DATA_W-1:0] rdata;

  // offset decode, full compare so aliases stay unmapped
  always_comb begin
    case (cmd.cmd.addr)
      `CLINT_MSIP_OFS:     reg_sel = e_reg_msip;
      `CLINT_MTIMECMP_OFS: reg_sel = e_reg_mtimecmp;
      `CLINT_MEIP_OFS:     reg_sel = e_reg_meip;
      `CLINT_MTIME_OFS:    reg_sel = e_reg_mtime;
      default:             reg_sel = e_reg_none;
    endcase
  end

  assign wr_not_rd = cmd.cmd.opcode inside {e_op_wr, e_op_uc_wr};
  assign retire    = cmd.v & resp_yumi_i;
  assign wr_commit = retire & wr_not_rd;
  assign cmd.yumi  = retire; // never above v

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      msip_r     <= 1'b0;
      meip_r     <= 1'b0;
      mtimecmp_r <= '0;
    end else if (wr_commit) begin
      case (reg_sel)
        e_reg_msip:     msip_r     <= cmd.cmd.data[0];
        e_reg_meip:     meip_r     <= cmd.cmd.data[0];
        e_reg_mtimecmp: mtimecmp_r <= cmd.cmd.data;
        default:        ; // mtime goes through the timer, none is dropped
      endcase
    end
  end

  // mtime lives in the timer, load it on the retiring edge
  assign tmr.mtime_set   = wr_commit & (reg_sel == e_reg_mtime);
  assign tmr.mtime_wdata = cmd.cmd.data;
  assign tmr.mtimecmp    = mtimecmp_r;

  always_comb begin
    rdata = '0;
    if (!wr_not_rd) begin
      case (reg_sel)
        e_reg_msip:     rdata = `CLINT_DATA_W'(msip_r);
        e_reg_meip:     rdata = `CLINT_DATA_W'(meip_r);
        e_reg_mtimecmp: rdata = mtimecmp_r;
        e_reg_mtime:    rdata = tmr.mtime;
        default:        rdata = '0;
      endcase
    end
  end

  // header echoed straight from the buffered command
  assign resp_o.opcode = cmd.cmd.opcode;
  assign resp_o.addr   = cmd.cmd.addr;
  assign resp_o.tag    = cmd.cmd.tag;
  assign resp_o.data   = rdata;

  assign software_irq_o = msip_r;
  assign external_irq_o = meip_r;

endmodule

`default_nettype wire

// File: hw/clint_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_timer (
  input  logic          clk_i,
  input  logic          rst_n_i,

  clint_timer_if.timer_mp tmr,

  output logic          timer_irq_o
);

  localparam int DIV_W = (`CLINT_TICK_DIV > 1) ? $clog2(`CLINT_TICK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`CLINT_TICK_DIV - 1);

  logic [DIV_W-1:0]         div_cnt_r;
  logic                     tick;
  logic [`CLINT_DATA_W-1:0] mtime_r;

  // prescaler, free running from reset release
  assign tick = (div_cnt_r == DIV_LAST);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_cnt_r <= '0;
    end else if (tick) begin
      div_cnt_r <= '0;
    end else begin
      div_cnt_r <= div_cnt_r + 1'b1;
    end
  end

  // a software set beats the tick
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtime_r <= '0;
    end else if (tmr.mtime_set) begin
      mtime_r <= tmr.mtime_wdata;
    end else if (tick) begin
      mtime_r <= mtime_r + 1'b1;
    end
  end

  assign tmr.mtime = mtime_r;

  // unsigned compare, high out of reset since 0 >= 0
  assign timer_irq_o = (mtime_r >= tmr.mtimecmp);

endmodule

`default_nettype wire

// File: hw/clint_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  input  clint_msg_pkg::clint_op_e  cmd_opcode_i,
  input  logic [`CLINT_ADDR_W-1:0]  cmd_addr_i,
  input  logic [`CLINT_TAG_W-1:0]   cmd_tag_i,
  input  logic [`CLINT_DATA_W-1:0]  cmd_data_i,

  output logic                      resp_v_o,
  input  logic                      resp_yumi_i,
  output clint_msg_pkg::clint_op_e  resp_opcode_o,
  output logic [`CLINT_ADDR_W-1:0]  resp_addr_o,
  output logic [`CLINT_TAG_W-1:0]   resp_tag_o,
  output logic [`CLINT_DATA_W-1:0]  resp_data_o,

  output logic                      software_irq_o,
  output logic                      timer_irq_o,
  output logic                      external_irq_o
);
  import clint_msg_pkg::*;

  clint_cmd_s  cmd_li;
  clint_resp_s resp_lo;

  clint_cmd_if   cmd_if ();
  clint_timer_if tmr_if ();

  assign cmd_li = '{opcode: cmd_opcode_i, addr: cmd_addr_i, tag: cmd_tag_i, data: cmd_data_i};

  clint_cmd_buffer u_cmd_buffer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_li),
    .cmd_o       (cmd_if.buf_mp)
  );

  clint_regs u_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd            (cmd_if.regs_mp),
    .tmr            (tmr_if.regs_mp),
    .resp_yumi_i    (resp_yumi_i),
    .resp_o         (resp_lo),
    .software_irq_o (software_irq_o),
    .external_irq_o (external_irq_o)
  );

  clint_timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .tmr         (tmr_if.timer_mp),
    .timer_irq_o (timer_irq_o)
  );

  assign resp_v_o      = cmd_if.v; // response valid while the entry waits
  assign resp_opcode_o = resp_lo.opcode;
  assign resp_addr_o   = resp_lo.addr;
  assign resp_tag_o    = resp_lo.tag;
  assign resp_data_o   = resp_lo.data;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the CLINT testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module clint_tb -o clint_sim \
  && { ./obj_dir/clint_sim +verilator+error+limit+10 > sim.log 2>&1 || true; } \
  || { echo "verilator build failed"; exit 1; }

cat sim.log
grep -qx "test passed" sim.log && echo "simulation ok" && exit 0 \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: test/clint_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_assert (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic                           cmd_v_i,
  input logic                           cmd_ready_o,
  input clint_msg_pkg::clint_op_e       cmd_opcode_i,
  input logic [`CLINT_ADDR_W-1:0]       cmd_addr_i,
  input logic [`CLINT_TAG_W-1:0]        cmd_tag_i,
  input logic [`CLINT_DATA_W-1:0]       cmd_data_i,
  input logic                           resp_v_o,
  input logic                           resp_yumi_i,
  input clint_msg_pkg::clint_op_e       resp_opcode_o,
  input logic [`CLINT_ADDR_W-1:0]       resp_addr_o,
  input logic [`CLINT_TAG_W-1:0]        resp_tag_o,
  input logic [`CLINT_DATA_W-1:0]       resp_data_o,
  input logic                           software_irq_o,
  input logic                           timer_irq_o,
  input logic                           external_irq_o
);
  import clint_msg_pkg::*;

  int unsigned              err_cnt = 0;
  clint_op_e                exp_op; // command in flight
  logic [`CLINT_ADDR_W-1:0] exp_addr;
  logic [`CLINT_TAG_W-1:0]  exp_tag;
  logic [`CLINT_DATA_W-1:0] exp_data;
  logic                     msip_sh;
  logic                     meip_sh;
  logic [`CLINT_DATA_W-1:0] mtimecmp_sh;
  logic [`CLINT_DATA_W-1:0] mtime_base; // last value set
  logic [`CLINT_DATA_W-1:0] mtime_last; // last value seen
  logic [`CLINT_DATA_W-1:0] elapsed;
  logic [`CLINT_DATA_W-1:0] rd_exp;
  logic                     is_wr;
  logic                     retire;
  logic                     rd_mtime;

  assign is_wr    = (exp_op == e_op_wr) || (exp_op == e_op_uc_wr);
  assign retire   = resp_v_o && resp_yumi_i;
  assign rd_mtime = retire && !is_wr && (exp_addr == `CLINT_MTIME_OFS);

  always_ff @(posedge clk_i) begin
    if (cmd_v_i && cmd_ready_o) begin
      exp_op   <= cmd_opcode_i;
      exp_addr <= cmd_addr_i;
      exp_tag  <= cmd_tag_i;
      exp_data <= cmd_data_i;
    end
    if (!rst_n_i) begin
      msip_sh     <= 1'b0;
      meip_sh     <= 1'b0;
      mtimecmp_sh <= '0;
      mtime_base  <= '0;
      mtime_last  <= '0;
      elapsed     <= '0;
    end else begin
      elapsed <= elapsed + 64'd1;
      if (retire && is_wr) begin
        case (exp_addr)
          `CLINT_MSIP_OFS:     msip_sh     <= exp_data[0];
          `CLINT_MEIP_OFS:     meip_sh     <= exp_data[0];
          `CLINT_MTIMECMP_OFS: mtimecmp_sh <= exp_data;
          `CLINT_MTIME_OFS: begin
            mtime_base <= exp_data;
            mtime_last <= exp_data;
            elapsed    <= '0;
          end
          default: ; // unmapped writes leave every register alone
        endcase
      end else if (rd_mtime) begin
        mtime_last <= resp_data_o;
      end
    end
  end

  always_comb begin
    rd_exp = '0;
    if (!is_wr) begin
      case (exp_addr)
        `CLINT_MSIP_OFS:     rd_exp = {{(`CLINT_DATA_W-1){1'b0}}, msip_sh};
        `CLINT_MEIP_OFS:     rd_exp = {{(`CLINT_DATA_W-1){1'b0}}, meip_sh};
        `CLINT_MTIMECMP_OFS: rd_exp = mtimecmp_sh;
        default:             rd_exp = '0;
      endcase
    end
  end

  a_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !resp_v_o && cmd_ready_o)
    else begin
      $error("CHECK FAILED resp_v_o %h cmd_ready_o %h after reset",
             $sampled(resp_v_o), $sampled(cmd_ready_o));
      err_cnt++;
    end

  a_reset_irq: assert property (@(posedge clk_i) $rose(rst_n_i) |->
      !software_irq_o && !external_irq_o && timer_irq_o)
    else begin
      $error("CHECK FAILED software_irq_o %h external_irq_o %h timer_irq_o %h after reset",
             $sampled(software_irq_o), $sampled(external_irq_o), $sampled(timer_irq_o));
      err_cnt++;
    end

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i) cmd_ready_o == !resp_v_o)
    else begin
      $error("CHECK FAILED cmd_ready_o got %h with resp_v_o %h",
             $sampled(cmd_ready_o), $sampled(resp_v_o));
      err_cnt++;
    end

  a_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_v_i && cmd_ready_o |=> resp_v_o)
    else begin
      $error("CHECK FAILED resp_v_o got %h exp 1 after accept", $sampled(resp_v_o));
      err_cnt++;
    end

  // mtime reads follow the live counter, so only their data may move
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_v_o && !resp_yumi_i |=> resp_v_o && $stable(resp_opcode_o) && $stable(resp_addr_o)
      && $stable(resp_tag_o) && (resp_addr_o == `CLINT_MTIME_OFS || $stable(resp_data_o)))
    else begin
      $error("CHECK FAILED resp_addr_o %h resp_tag_o %h resp_data_o %h moved under stall",
             $sampled(resp_addr_o), $sampled(resp_tag_o), $sampled(resp_data_o));
      err_cnt++;
    end

  a_echo: assert property (@(posedge clk_i) disable iff (!rst_n_i) resp_v_o |->
      resp_opcode_o == exp_op && resp_addr_o == exp_addr && resp_tag_o == exp_tag)
    else begin
      $error("CHECK FAILED resp_opcode_o %h resp_addr_o %h resp_tag_o %h exp %h %h %h",
             $sampled(resp_opcode_o), $sampled(resp_addr_o), $sampled(resp_tag_o),
             $sampled(exp_op), $sampled(exp_addr), $sampled(exp_tag));
      err_cnt++;
    end

  a_sw_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i) software_irq_o == msip_sh)
    else begin
      $error("CHECK FAILED software_irq_o got %h exp %h",
             $sampled(software_irq_o), $sampled(msip_sh));
      err_cnt++;
    end

  a_ext_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i) external_irq_o == meip_sh)
    else begin
      $error("CHECK FAILED external_irq_o got %h exp %h",
             $sampled(external_irq_o), $sampled(meip_sh));
      err_cnt++;
    end

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      retire && !rd_mtime |-> resp_data_o == rd_exp)
    else begin
      $error("CHECK FAILED resp_data_o got %h exp %h", $sampled(resp_data_o), $sampled(rd_exp));
      err_cnt++;
    end

  a_mtime: assert property (@(posedge clk_i) disable iff (!rst_n_i) rd_mtime |->
      resp_data_o >= mtime_base && resp_data_o >= mtime_last
      && resp_data_o <= mtime_base + elapsed / `CLINT_TICK_DIV + 64'd1)
    else begin
      $error("CHECK FAILED resp_data_o (mtime) got %h base %h last %h elapsed %h",
             $sampled(resp_data_o), $sampled(mtime_base), $sampled(mtime_last),
             $sampled(elapsed));
      err_cnt++;
    end

  a_timer_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i) rd_mtime |->
      timer_irq_o == (resp_data_o >= mtimecmp_sh))
    else begin
      $error("CHECK FAILED timer_irq_o got %h mtime %h mtimecmp %h",
             $sampled(timer_irq_o), $sampled(resp_data_o), $sampled(mtimecmp_sh));
      err_cnt++;
    end

endmodule

`default_nettype wire

// File: test/clint_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_tb;
  import clint_msg_pkg::*;

  localparam int STEP_LIMIT = 100; // cycles allowed per handshake
  localparam int IRQ_LIMIT  = 400;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     cmd_v_i;
  logic                     cmd_ready_o;
  clint_op_e                cmd_opcode_i;
  logic [`CLINT_ADDR_W-1:0] cmd_addr_i;
  logic [`CLINT_TAG_W-1:0]  cmd_tag_i;
  logic [`CLINT_DATA_W-1:0] cmd_data_i;
  logic                     resp_v_o;
  logic                     resp_yumi_i;
  clint_op_e                resp_opcode_o;
  logic [`CLINT_ADDR_W-1:0] resp_addr_o;
  logic [`CLINT_TAG_W-1:0]  resp_tag_o;
  logic [`CLINT_DATA_W-1:0] resp_data_o;
  logic                     software_irq_o;
  logic                     timer_irq_o;
  logic                     external_irq_o;

  int                       seed;
  logic [`CLINT_TAG_W-1:0]  tag_q;

  clint_top dut0 (.*);

  bind clint_top clint_assert u_chk (.*);

  always #50 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("test failed");
    $fatal(1, "%s", why);
  endtask

  // stop at the first assertion error
  always @(negedge clk_i) begin
    if (dut0.u_chk.err_cnt != 0) begin
      abort_run("an assertion in the checker reported an error");
    end
  end

  // one command through the buffer, with a random stall before retire
  task automatic run_cmd(input clint_op_e op, input logic [`CLINT_ADDR_W-1:0] addr,
                         input logic [`CLINT_DATA_W-1:0] data);
    int          n;
    int          hold;
    logic [31:0] rnd;
    rnd  = $random(seed);
    hold = int'(rnd[2:0]) % 5;
    @(posedge clk_i);
    cmd_v_i      <= 1'b1;
    cmd_opcode_i <= op;
    cmd_addr_i   <= addr;
    cmd_tag_i    <= tag_q;
    cmd_data_i   <= data;
    tag_q        = tag_q + 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!cmd_ready_o) begin
      n++;
      if (n > STEP_LIMIT) abort_run("timed out waiting for cmd_ready_o");
      @(negedge clk_i);
    end
    @(posedge clk_i); // accepted on this edge
    cmd_v_i <= 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!resp_v_o) begin
      n++;
      if (n > STEP_LIMIT) abort_run("timed out waiting for resp_v_o");
      @(negedge clk_i);
    end
    repeat (hold) @(posedge clk_i);
    @(posedge clk_i);
    resp_yumi_i <= 1'b1;
    @(posedge clk_i); // retires here
    resp_yumi_i <= 1'b0;
  endtask

  initial begin
    logic [`CLINT_ADDR_W-1:0] addr;
    logic [31:0]              rnd;
    int                       n;
    seed         = 32'h8548;
    tag_q        = '0;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    cmd_v_i      = 1'b0;
    cmd_opcode_i = e_op_rd;
    cmd_addr_i   = '0;
    cmd_tag_i    = '0;
    cmd_data_i   = '0;
    resp_yumi_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    run_cmd(e_op_wr, `CLINT_MSIP_OFS, 64'h1);
    run_cmd(e_op_rd, `CLINT_MSIP_OFS, '0);
    run_cmd(e_op_uc_wr, `CLINT_MEIP_OFS, 64'hFFFF_FFFF_FFFF_FFFF);
    run_cmd(e_op_uc_rd, `CLINT_MEIP_OFS, '0);
    run_cmd(e_op_wr, `CLINT_MSIP_OFS, 64'h2); // bit 0 clear
    run_cmd(e_op_rd, `CLINT_MSIP_OFS, '0);
    run_cmd(e_op_wr, `CLINT_MEIP_OFS, 64'h0);

    run_cmd(e_op_wr, `CLINT_MTIMECMP_OFS, 64'h0123_4567_89AB_CDEF);
    run_cmd(e_op_rd, `CLINT_MTIMECMP_OFS, '0);
    run_cmd(e_op_wr, 16'h0008, 64'hDEAD_BEEF_0000_0001);
    run_cmd(e_op_rd, 16'h0008, '0);
    run_cmd(e_op_uc_wr, 16'h4004, 64'h5555_5555_5555_5555);
    run_cmd(e_op_uc_rd, 16'h4004, '0);
    run_cmd(e_op_rd, `CLINT_MTIMECMP_OFS, '0);

    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'd0:    addr = `CLINT_MSIP_OFS;
        2'd1:    addr = `CLINT_MEIP_OFS;
        2'd2:    addr = `CLINT_MTIMECMP_OFS;
        default: addr = 16'h0010;
      endcase
      run_cmd(clint_op_e'(rnd[3:2]), addr, {$random(seed), $random(seed)});
    end

    run_cmd(e_op_wr, `CLINT_MTIME_OFS, 64'h0000_0001_0000_0000);
    run_cmd(e_op_rd, `CLINT_MTIME_OFS, '0);
    repeat (30) @(posedge clk_i);
    run_cmd(e_op_rd, `CLINT_MTIME_OFS, '0);
    run_cmd(e_op_uc_rd, `CLINT_MTIME_OFS, '0);

    // timer interrupt, compare value a few ticks ahead of mtime
    run_cmd(e_op_wr, `CLINT_MTIME_OFS, 64'h100);
    run_cmd(e_op_wr, `CLINT_MTIMECMP_OFS, 64'h110);
    run_cmd(e_op_rd, `CLINT_MTIME_OFS, '0);
    n = 0;
    @(negedge clk_i);
    while (!timer_irq_o) begin
      n++;
      if (n > IRQ_LIMIT) abort_run("timed out waiting for timer_irq_o");
      @(negedge clk_i);
    end
    run_cmd(e_op_rd, `CLINT_MTIME_OFS, '0);

    repeat (2) @(posedge clk_i);
    if (dut0.u_chk.err_cnt != 0) begin
      abort_run("the checker counted assertion errors");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
